//--- memory_stage.f
verilog/mips_isa_pkg.sv
verilog/mem_cfg_pkg.sv
verilog/access_align.sv
verilog/data_memory.sv
verilog/load_extract.sv
verilog/memory_stage.sv
testbench/memory_stage_assert.sv
testbench/memory_stage_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the memory stage testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module memory_stage_tb \
    -f memory_stage.f

./obj_dir/Vmemory_stage_tb +verilator+error+limit+1000 | tee sim.log

if grep -q '^>>> PASS$' sim.log
then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

//--- testbench/memory_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module memory_stage_tb;

    localparam int CLK_PERIOD = 8;
    localparam int SEED       = 56389;
    localparam int WINDOW     = 16;
    localparam int N_RAND     = 300;
    // Each random access may bring one follow-up load
    localparam int N_OPS      = 2 * WINDOW + 2 * N_RAND;

    logic                       i_clk;
    logic                       i_rst;
    logic                       i_valid;
    logic                       i_is_store;
    mips_isa_pkg::acc_size_t    i_size;
    logic                       i_unsigned;
    mips_isa_pkg::word_t        i_addr;
    mips_isa_pkg::word_t        i_wdata;
    mips_isa_pkg::reg_idx_t     i_rd;
    logic                       o_load_valid;
    mips_isa_pkg::word_t        o_rdata;
    mips_isa_pkg::reg_idx_t     o_rd;
    logic                       o_misaligned;

    // Byte model of the window indexed by {word, offset}
    logic [7:0]                 ref_mem [4*WINDOW];
    mips_isa_pkg::word_t        exp_data_q [$];
    mips_isa_pkg::reg_idx_t     exp_rd_q [$];
    int                         errors = 0;
    int                         loads_issued = 0;
    int                         results_seen = 0;

    memory_stage DUT
    (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_valid        (i_valid),
        .i_is_store     (i_is_store),
        .i_size         (i_size),
        .i_unsigned     (i_unsigned),
        .i_addr         (i_addr),
        .i_wdata        (i_wdata),
        .i_rd           (i_rd),
        .o_load_valid   (o_load_valid),
        .o_rdata        (o_rdata),
        .o_rd           (o_rd),
        .o_misaligned   (o_misaligned)
    );

    bind memory_stage memory_stage_assert u_assert
    (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_valid        (i_valid),
        .i_is_store     (i_is_store),
        .i_size         (i_size),
        .i_addr         (i_addr),
        .o_load_valid   (o_load_valid),
        .o_rdata        (o_rdata),
        .o_misaligned   (o_misaligned)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD/2) i_clk = ~i_clk;
    end

    initial
    begin
        #((N_OPS + 50) * CLK_PERIOD);
        $display("Timeout, the run did not finish within %0d cycles", N_OPS + 50);
        $display(">>> FAIL");
        $finish;
    end

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic logic is_legal(input mips_isa_pkg::acc_size_t size,
                                      input mips_isa_pkg::byte_off_t off);
        if (size == mips_isa_pkg::SIZE_BYTE)
            return 1'b1;
        if (size == mips_isa_pkg::SIZE_HALF)
            return ~off[0];
        return off == 2'b00;
    endfunction

    // Upper address bits are random since the RAM only sees the word index
    function automatic mips_isa_pkg::word_t window_addr(input logic [3:0] word,
                                                        input mips_isa_pkg::byte_off_t off);
        logic [21:0] upper;
        upper = 22'($urandom);
        return {upper, 4'h8, word, off};
    endfunction

    // Little endian with the low data byte at the addressed byte
    task automatic apply_store(input logic [3:0] word, input mips_isa_pkg::byte_off_t off,
                               input mips_isa_pkg::acc_size_t size,
                               input mips_isa_pkg::word_t data);
        logic [5:0] base;
        base = {word, off};
        ref_mem[base] = data[7:0];
        if (size != mips_isa_pkg::SIZE_BYTE)
            ref_mem[base + 6'd1] = data[15:8];
        if (size == mips_isa_pkg::SIZE_WORD)
        begin
            ref_mem[base + 6'd2] = data[23:16];
            ref_mem[base + 6'd3] = data[31:24];
        end
    endtask

    function automatic mips_isa_pkg::word_t predict_load(input logic [3:0] word,
                                                         input mips_isa_pkg::byte_off_t off,
                                                         input mips_isa_pkg::acc_size_t size,
                                                         input logic uns);
        logic [5:0]     base;
        logic [7:0]     b;
        logic [15:0]    h;
        base = {word, off};
        b    = ref_mem[base];
        h    = {ref_mem[base + 6'd1], ref_mem[base]};
        if (size == mips_isa_pkg::SIZE_BYTE)
            return uns ? {24'h0, b} : {{24{b[7]}}, b};
        if (size == mips_isa_pkg::SIZE_HALF)
            return uns ? {16'h0, h} : {{16{h[15]}}, h};
        return {ref_mem[base + 6'd3], ref_mem[base + 6'd2], h};
    endfunction

    task automatic send_access(input logic store, input mips_isa_pkg::acc_size_t size,
                               input logic uns, input logic [3:0] word,
                               input mips_isa_pkg::byte_off_t off,
                               input mips_isa_pkg::word_t data,
                               input mips_isa_pkg::reg_idx_t rd);
        @(posedge i_clk);
        i_valid    <= 1'b1;
        i_is_store <= store;
        i_size     <= size;
        i_unsigned <= uns;
        i_addr     <= window_addr(word, off);
        i_wdata    <= data;
        i_rd       <= rd;
        if (is_legal(size, off))
        begin
            if (store)
                apply_store(word, off, size, data);
            else
            begin
                exp_data_q.push_back(predict_load(word, off, size, uns));
                exp_rd_q.push_back(rd);
                loads_issued++;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Result checking
    //////////////////////////////////////////////////

    // Outputs are settled by the falling edge
    always @(negedge i_clk)
    begin : check_result
        mips_isa_pkg::word_t    exp_data;
        mips_isa_pkg::reg_idx_t exp_rd;
        if (o_load_valid === 1'b1)
        begin
            if (exp_data_q.size() == 0)
            begin
                errors++;
                $display("A load result appeared with no load outstanding");
            end
            else
            begin
                exp_data = exp_data_q.pop_front();
                exp_rd   = exp_rd_q.pop_front();
                results_seen++;
                assert (o_rdata === exp_data)
                else
                begin
                    errors++;
                    $display("ERROR o_rdata got %h expected %h", o_rdata, exp_data);
                end
                assert (o_rd === exp_rd)
                else
                begin
                    errors++;
                    $display("ERROR o_rd got %h expected %h", o_rd, exp_rd);
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial
    begin
        int                         seed_draw;
        int                         count_errors;
        int                         assert_fails;
        logic                       store;
        mips_isa_pkg::acc_size_t    size;
        logic                       uns;
        logic [3:0]                 word;
        mips_isa_pkg::byte_off_t    off;
        mips_isa_pkg::word_t        data;
        mips_isa_pkg::reg_idx_t     rd;
        seed_draw    = $urandom(SEED);
        count_errors = 0;
        i_rst      = 1'b1;
        i_valid    = 1'b0;
        i_is_store = 1'b0;
        i_size     = mips_isa_pkg::SIZE_WORD;
        i_unsigned = 1'b0;
        i_addr     = '0;
        i_wdata    = '0;
        i_rd       = '0;
        repeat (4) @(posedge i_clk);
        i_rst <= 1'b0;

        // Fill the window so that every later load has known data
        for (int w = 0; w < WINDOW; w++)
            send_access(1'b1, mips_isa_pkg::SIZE_WORD, 1'b0, 4'(w), 2'b00, $urandom, 5'd0);

        for (int n = 0; n < N_RAND; n++)
        begin
            store = 1'($urandom);
            size  = 2'($urandom_range(2, 0));
            uns   = 1'($urandom);
            word  = 4'($urandom);
            off   = 2'($urandom);
            data  = $urandom;
            rd    = 5'($urandom);
            send_access(store, size, uns, word, off, data, rd);
            if (!is_legal(size, off))
            begin
                // Word must be untouched by the rejected access
                send_access(1'b0, mips_isa_pkg::SIZE_WORD, 1'b0, word, 2'b00, $urandom, rd);
            end
            else if (store && $urandom_range(1, 0) == 1)
            begin
                send_access(1'b0, size, uns, word, off, $urandom, rd);
            end
        end

        for (int w = 0; w < WINDOW; w++)
            send_access(1'b0, mips_isa_pkg::SIZE_WORD, 1'b0, 4'(w), 2'b00, $urandom, 5'(w));

        // Last load is accepted here and its result is due one cycle later
        @(posedge i_clk);
        i_valid <= 1'b0;
        repeat (2) @(posedge i_clk);

        assert (results_seen == loads_issued)
        else
        begin
            count_errors++;
            $display("Load count mismatch, %0d issued but %0d results received",
                     loads_issued, results_seen);
        end
        assert_fails = DUT.u_assert.fail_count;
        $display("Done: %0d loads, %0d results, %0d errors, %0d count errors, %0d assert fails",
                 loads_issued, results_seen, errors, count_errors, assert_fails);
        if (errors == 0 && count_errors == 0 && assert_fails == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/memory_stage_assert.sv
`timescale 1ns/1ps
`default_nettype none

module memory_stage_assert
    (
        input wire                          i_clk,
        input wire                          i_rst,
        input wire                          i_valid,
        input wire                          i_is_store,
        input wire mips_isa_pkg::acc_size_t i_size,
        input wire mips_isa_pkg::word_t     i_addr,
        input wire                          o_load_valid,
        input wire mips_isa_pkg::word_t     o_rdata,
        input wire                          o_misaligned
    );

    int     fail_count = 0;
    logic   legal;
    logic   load_req;
    logic   bad_req;

    // Byte anywhere, half on an even address, word on a word boundary
    assign legal = (i_size == mips_isa_pkg::SIZE_BYTE)
                || (i_size == mips_isa_pkg::SIZE_HALF && !i_addr[0])
                || (i_addr[1:0] == 2'b00);

    assign load_req = !i_rst && i_valid && !i_is_store && legal;
    assign bad_req  = !i_rst && i_valid && !legal;

    //////////////////////////////////////////////////
    // Result and flag timing
    //////////////////////////////////////////////////

    a_load_follows: assert property (@(posedge i_clk) load_req |=> o_load_valid)
    else
    begin
        fail_count++;
        $error("Aligned load was not followed by o_load_valid");
    end

    // Also holds through reset and until the first request
    a_no_stray_load: assert property (@(posedge i_clk) !load_req |=> !o_load_valid)
    else
    begin
        fail_count++;
        $error("o_load_valid rose without an aligned load one cycle before");
    end

    a_mis_flag: assert property (@(posedge i_clk) bad_req |=> o_misaligned && !o_load_valid)
    else
    begin
        fail_count++;
        $error("Misaligned access did not raise o_misaligned alone");
    end

    a_no_stray_mis: assert property (@(posedge i_clk) !bad_req |=> !o_misaligned)
    else
    begin
        fail_count++;
        $error("o_misaligned rose without a misaligned access one cycle before");
    end

    a_rdata_known: assert property (@(posedge i_clk) o_load_valid |-> !$isunknown(o_rdata))
    else
    begin
        fail_count++;
        $error("Load result holds unknown bits");
    end

endmodule

`default_nettype wire

//--- verilog/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

module memory_stage
    (
        input  wire                             i_clk,
        input  wire                             i_rst,
        input  wire                             i_valid,
        input  wire                             i_is_store,
        input  wire mips_isa_pkg::acc_size_t    i_size,
        input  wire                             i_unsigned,
        input  wire mips_isa_pkg::word_t        i_addr,
        input  wire mips_isa_pkg::word_t        i_wdata,
        input  wire mips_isa_pkg::reg_idx_t     i_rd,
        output logic                            o_load_valid,
        output mips_isa_pkg::word_t             o_rdata,
        output mips_isa_pkg::reg_idx_t          o_rd,
        output logic                            o_misaligned
    );

    // Request side, combinational from access_align
    logic                       wr_en;
    logic                       rd_en;
    logic                       misaligned;
    mem_cfg_pkg::mem_idx_t      idx;
    mem_cfg_pkg::byte_en_t      byte_en;
    mips_isa_pkg::word_t        lane_data;
    mips_isa_pkg::word_t        ram_word;

    // Sideband that follows the read through the RAM latency
    logic                       load_valid_q;
    logic                       misaligned_q;
    mips_isa_pkg::acc_size_t    size_q;
    logic                       unsigned_q;
    mips_isa_pkg::byte_off_t    off_q;
    mips_isa_pkg::reg_idx_t     rd_q;

    access_align u_align
    (
        .i_valid        (i_valid),
        .i_is_store     (i_is_store),
        .i_size         (i_size),
        .i_addr         (i_addr),
        .i_wdata        (i_wdata),
        .o_wr_en        (wr_en),
        .o_rd_en        (rd_en),
        .o_idx          (idx),
        .o_byte_en      (byte_en),
        .o_lane_data    (lane_data),
        .o_misaligned   (misaligned)
    );

    data_memory u_dmem
    (
        .i_clk          (i_clk),
        .i_wr_en        (wr_en),
        .i_rd_en        (rd_en),
        .i_idx          (idx),
        .i_byte_en      (byte_en),
        .i_wdata        (lane_data),
        .o_rdata        (ram_word)
    );

    //////////////////////////////////////////////////
    // Sideband register
    //////////////////////////////////////////////////

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            load_valid_q <= 1'b0;
            misaligned_q <= 1'b0;
        end
        else
        begin
            load_valid_q <= rd_en;
            misaligned_q <= misaligned;
        end
    end

    // Payload only matters when load_valid_q is set
    always_ff @(posedge i_clk)
    begin
        if (i_valid)
        begin
            size_q     <= i_size;
            unsigned_q <= i_unsigned;
            off_q      <= i_addr[1:0];
            rd_q       <= i_rd;
        end
    end

    load_extract u_extract
    (
        .i_word         (ram_word),
        .i_size         (size_q),
        .i_unsigned     (unsigned_q),
        .i_off          (off_q),
        .o_result       (o_rdata)
    );

    assign o_load_valid = load_valid_q;
    assign o_misaligned = misaligned_q;
    assign o_rd         = rd_q;

endmodule

`default_nettype wire

//--- verilog/load_extract.sv
`timescale 1ns/1ps
`default_nettype none

module load_extract
    (
        input  wire mips_isa_pkg::word_t        i_word,
        input  wire mips_isa_pkg::acc_size_t    i_size,
        input  wire                             i_unsigned,
        input  wire mips_isa_pkg::byte_off_t    i_off,
        output mips_isa_pkg::word_t             o_result
    );

    logic [7:0]     sel_byte;
    logic [15:0]    sel_half;
    logic           byte_fill;
    logic           half_fill;

    //////////////////////////////////////////////////
    // Lane selection
    //////////////////////////////////////////////////

    always_comb
    begin
        case (i_off)
            2'd0:
            begin
                sel_byte = i_word[7:0];
            end
            2'd1:
            begin
                sel_byte = i_word[15:8];
            end
            2'd2:
            begin
                sel_byte = i_word[23:16];
            end
            default:
            begin
                sel_byte = i_word[31:24];
            end
        endcase
    end

    // Halves are aligned, so only offset bit 1 matters
    assign sel_half = i_off[1] ? i_word[31:16] : i_word[15:0];

    //////////////////////////////////////////////////
    // Extension
    //////////////////////////////////////////////////

    // lbu and lhu fill with zeros
    assign byte_fill = ~i_unsigned & sel_byte[7];
    assign half_fill = ~i_unsigned & sel_half[15];

    always_comb
    begin
        case (i_size)
            mips_isa_pkg::SIZE_BYTE:
            begin
                o_result = {{(mips_isa_pkg::WORD_W-8){byte_fill}}, sel_byte};
            end
            mips_isa_pkg::SIZE_HALF:
            begin
                o_result = {{(mips_isa_pkg::WORD_W-16){half_fill}}, sel_half};
            end
            default:
            begin
                o_result = i_word;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/data_memory.sv
`timescale 1ns/1ps
`default_nettype none

module data_memory
    (
        input  wire                         i_clk,
        input  wire                         i_wr_en,
        input  wire                         i_rd_en,
        input  wire mem_cfg_pkg::mem_idx_t  i_idx,
        input  wire mem_cfg_pkg::byte_en_t  i_byte_en,
        input  wire mips_isa_pkg::word_t    i_wdata,
        output mips_isa_pkg::word_t         o_rdata
    );

    // Storage array, contents undefined until written
    mips_isa_pkg::word_t mem [mem_cfg_pkg::MEM_DEPTH];

    //////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////

    // Only enabled lanes change, the rest of the word is kept
    always_ff @(posedge i_clk)
    begin
        for (int lane = 0; lane < mem_cfg_pkg::BYTE_LANES; lane++)
        begin
            if (i_wr_en && i_byte_en[lane])
            begin
                mem[i_idx][lane*8 +: 8] <= i_wdata[lane*8 +: 8];
            end
        end
    end

    //////////////////////////////////////////////////
    // Read port
    //////////////////////////////////////////////////

    // One cycle latency, output holds between reads
    always_ff @(posedge i_clk)
    begin
        if (i_rd_en)
        begin
            o_rdata <= mem[i_idx];
        end
    end

endmodule

`default_nettype wire

//--- verilog/access_align.sv
`timescale 1ns/1ps
`default_nettype none

module access_align
    (
        input  wire                         i_valid,
        input  wire                         i_is_store,
        input  wire mips_isa_pkg::acc_size_t i_size,
        input  wire mips_isa_pkg::word_t    i_addr,
        input  wire mips_isa_pkg::word_t    i_wdata,
        output logic                        o_wr_en,
        output logic                        o_rd_en,
        output mem_cfg_pkg::mem_idx_t       o_idx,
        output mem_cfg_pkg::byte_en_t       o_byte_en,
        output mips_isa_pkg::word_t         o_lane_data,
        output logic                        o_misaligned
    );

    mips_isa_pkg::byte_off_t    off;
    logic                       bad_align;

    assign off = i_addr[1:0];

    //////////////////////////////////////////////////
    // Alignment check
    //////////////////////////////////////////////////

    // Bytes are always legal, halves need an even address,
    // words need both offset bits clear
    always_comb
    begin
        case (i_size)
            mips_isa_pkg::SIZE_BYTE:
            begin
                bad_align = 1'b0;
            end
            mips_isa_pkg::SIZE_HALF:
            begin
                bad_align = off[0];
            end
            default:
            begin
                bad_align = (off != 2'b00);
            end
        endcase
    end

    // Misaligned accesses never reach the RAM
    assign o_wr_en      = i_valid &  i_is_store & ~bad_align;
    assign o_rd_en      = i_valid & ~i_is_store & ~bad_align;
    assign o_misaligned = i_valid & bad_align;

    // Word index from the bits above the offset, upper bits wrap
    assign o_idx = i_addr[mem_cfg_pkg::MEM_IDX_W+1:2];

    //////////////////////////////////////////////////
    // Store lane placement
    //////////////////////////////////////////////////

    // Data is replicated to every lane so that the enables alone pick the target
    always_comb
    begin
        case (i_size)
            mips_isa_pkg::SIZE_BYTE:
            begin
                o_lane_data = {mem_cfg_pkg::BYTE_LANES{i_wdata[7:0]}};
                o_byte_en   = mem_cfg_pkg::byte_en_t'(1) << off;
            end
            mips_isa_pkg::SIZE_HALF:
            begin
                o_lane_data = {(mem_cfg_pkg::BYTE_LANES/2){i_wdata[15:0]}};
                // Upper or lower half of the word
                o_byte_en   = off[1] ? 4'b1100 : 4'b0011;
            end
            default:
            begin
                o_lane_data = i_wdata;
                o_byte_en   = '1;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/mem_cfg_pkg.sv
`default_nettype none

package mem_cfg_pkg;

    //////////////////////////////////////////////////
    // Data memory geometry
    //////////////////////////////////////////////////

    // Words held by the RAM
    localparam int MEM_DEPTH = 256;
    localparam int MEM_IDX_W = $clog2(MEM_DEPTH);

    typedef logic [MEM_IDX_W-1:0] mem_idx_t;

    // One write enable per byte lane
    localparam int BYTE_LANES = 4;

    typedef logic [BYTE_LANES-1:0] byte_en_t;

endpackage

`default_nettype wire

//--- verilog/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

    //////////////////////////////////////////////////
    // Data path widths
    //////////////////////////////////////////////////

    localparam int WORD_W    = 32;
    localparam int REG_IDX_W = 5;
    localparam int OFF_W     = 2;

    // One data or address word
    typedef logic [WORD_W-1:0] word_t;

    // Architectural register number, r0 to r31
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // Byte position inside a word
    typedef logic [OFF_W-1:0] byte_off_t;

    //////////////////////////////////////////////////
    // Access size codes
    //////////////////////////////////////////////////

    typedef logic [1:0] acc_size_t;

    // lb, lbu, sb
    localparam acc_size_t SIZE_BYTE = 2'd0;
    // lh, lhu, sh
    localparam acc_size_t SIZE_HALF = 2'd1;
    // lw, sw
    localparam acc_size_t SIZE_WORD = 2'd2;

endpackage

`default_nettype wire
